// File: design/snes_mem_pkg.sv
/*
 * SNES memory core definitions
 * Address widths, cartridge header offsets and the shared enums
 */
package snes_mem_pkg;

	// ==========================================================
	// Address widths
	// ==========================================================
	localparam int ROM_AW       = 24;
	localparam int WRAM_AW      = 17;
	localparam int BSRAM_AW     = 20;
	// SDRAM is addressed in 16-bit words
	localparam int SDRAM_AW     = 23;
	localparam int MASK_W       = 24;
	localparam int SAV_SECTOR_W = 12;

	// ==========================================================
	// Memory map and header layout
	// ==========================================================
	localparam int unsigned SMC_HDR_BYTES = 512;

	// Work RAM sits near the top of SDRAM
	localparam logic [6:0] WRAM_SDRAM_BASE = 7'b1110111;

	localparam logic [14:0] HDR_MAPPER_OFS  = 15'h7FD4;
	localparam logic [14:0] HDR_TYPE_OFS    = 15'h7FD6;
	localparam logic [14:0] HDR_RAMSIZE_OFS = 15'h7FD8;
	localparam logic [14:0] HDR_COMPANY_OFS = 15'h7FDA;

	localparam logic [3:0] ROM_MIN_SIZE_CODE = 4'd7;
	localparam logic [3:0] GSU_RAM_SIZE_CODE = 4'd6;

	// ==========================================================
	// Enums
	// ==========================================================
	typedef enum logic [1:0] {
		LOROM   = 2'd0,
		HIROM   = 2'd1,
		EXHIROM = 2'd2
	} map_mode_e;

	// Coprocessor code, upper nibble of rom_type
	typedef enum logic [3:0] {
		CHIP_NONE = 4'h0,
		CHIP_SDD1 = 4'h5,
		CHIP_SA1  = 4'h6,
		CHIP_GSU  = 4'h7,
		CHIP_DSP1 = 4'h8,
		CHIP_DSP2 = 4'h9,
		CHIP_DSP3 = 4'hA,
		CHIP_DSP4 = 4'hB,
		CHIP_OBC1 = 4'hC
	} chip_e;

	typedef enum logic {
		BK_IDLE = 1'b0,
		BK_BUSY = 1'b1
	} bk_state_e;

endpackage

// File: design/load_ctrl.sv
/*
 * Loader control
 * Splits the download stream into cartridge and sound-program loads,
 * strips the copier header and sequences the console core reset
 */
`timescale 1ns/100ps

module load_ctrl import snes_mem_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET_N,
	input  logic              user_reset,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  logic              ioctl_wr,
	input  logic [24:0]       ioctl_addr,
	input  logic [23:0]       ioctl_filesize,
	output logic              cart_download,
	output logic              spc_mode,
	output logic              core_reset_n,
	output logic              dl_start,
	output logic [ROM_AW-1:0] cart_addr
);

	logic        spc_download;
	logic        run_req;
	logic        dl_q;
	logic [1:0]  phase;
	logic [24:0] hdr_len;
	logic [24:0] addr_adj;

	// Index 0 and 1 are cartridge images, 2 is an SPC file
	assign cart_download = ioctl_download && (ioctl_index[7:1] == 7'd0);
	assign spc_download  = ioctl_download && (ioctl_index == 8'd2);

	// Image sizes with 512 left over carry a copier header
	assign hdr_len   = (ioctl_filesize[9:0] == 10'(SMC_HDR_BYTES)) ? 25'(SMC_HDR_BYTES) : '0;
	assign addr_adj  = ioctl_addr - hdr_len;
	assign cart_addr = addr_adj[ROM_AW-1:0];

	assign run_req = !user_reset && !ioctl_download;

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			phase        <= 2'd0;
			core_reset_n <= 1'b0;
			spc_mode     <= 1'b0;
			dl_q         <= 1'b0;
			dl_start     <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			// Release only on a fixed phase of the divider
			if (phase == 2'd2)
				core_reset_n <= run_req;

			dl_q     <= ioctl_download;
			dl_start <= ioctl_download && !dl_q;

			if (user_reset)
				spc_mode <= 1'b0;
			if (ioctl_wr)
				spc_mode <= spc_download;
		end
	end

	a_one_download_kind: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		!(cart_download && spc_download));

endmodule

// File: design/cart_header_detect.sv
/*
 * Cartridge header detection
 * Captures the internal header while the ROM streams in, then derives
 * the coprocessor type and the ROM and save-RAM address masks
 */
`timescale 1ns/100ps

module cart_header_detect import snes_mem_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET_N,
	input  logic              cart_download,
	input  logic              ioctl_wr,
	input  logic [ROM_AW-1:0] cart_addr,
	input  logic [15:0]       ioctl_dout,
	input  map_mode_e         map_mode,
	input  logic              video_region,
	output logic [7:0]        rom_type,
	output logic [MASK_W-1:0] rom_mask,
	output logic [MASK_W-1:0] ram_mask,
	output logic              pal
);

	logic [8:0] hdr_prefix;
	logic [7:0] mapper;
	logic [7:0] hdr_type;
	logic [7:0] company;
	logic [3:0] rom_size;
	logic [3:0] rom_size_eff;
	logic [3:0] ram_size;
	chip_e      chip;

	// Bank holding the header for each mapping
	always_comb begin
		case (map_mode)
			HIROM:   hdr_prefix = 9'h001;
			EXHIROM: hdr_prefix = 9'h081;
			default: hdr_prefix = 9'h000;
		endcase
	end

	assign rom_size_eff = (rom_size < ROM_MIN_SIZE_CODE) ? ROM_MIN_SIZE_CODE : rom_size;

	// ==========================================================
	// Coprocessor classification, first match wins
	// ==========================================================
	always_comb begin
		chip = CHIP_NONE;
		if (mapper == 8'h30 && hdr_type == 8'h05 && company == 8'hB2)
			chip = CHIP_DSP3;
		else if (((mapper == 8'h20 || mapper == 8'h21) && hdr_type == 8'h03) ||
				(mapper == 8'h30 && hdr_type == 8'h05) ||
				(mapper == 8'h31 && (hdr_type == 8'h03 || hdr_type == 8'h05)))
			chip = CHIP_DSP1;
		else if (mapper == 8'h20 && hdr_type == 8'h05)
			chip = CHIP_DSP2;
		else if (mapper == 8'h30 && hdr_type == 8'h03)
			chip = CHIP_DSP4;
		else if (mapper == 8'h30 && hdr_type == 8'h25)
			chip = CHIP_OBC1;
		else if (mapper == 8'h32 && (hdr_type == 8'h43 || hdr_type == 8'h45))
			chip = CHIP_SDD1;
		else if (mapper == 8'h20 && (hdr_type == 8'h13 || hdr_type == 8'h14 ||
				hdr_type == 8'h15 || hdr_type == 8'h1A))
			chip = CHIP_GSU;
		else if (mapper == 8'h23 && (hdr_type == 8'h32 || hdr_type == 8'h34 ||
				hdr_type == 8'h35))
			chip = CHIP_SA1;
	end

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			rom_type <= 8'd0;
			pal      <= 1'b0;
			ram_size <= 4'd0;
			rom_size <= 4'd0;
			mapper   <= 8'd0;
			hdr_type <= 8'd0;
			company  <= 8'd0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				if (cart_addr == '0) begin
					ram_size <= 4'd0;
					rom_type <= {6'd0, map_mode};
				end
				if (cart_addr == {hdr_prefix, HDR_MAPPER_OFS})
					mapper <= ioctl_dout[15:8];
				if (cart_addr == {hdr_prefix, HDR_TYPE_OFS})
					{rom_size, hdr_type} <= ioctl_dout[11:0];
				if (cart_addr == {hdr_prefix, HDR_RAMSIZE_OFS})
					ram_size <= ioctl_dout[3:0];
				if (cart_addr == {hdr_prefix, HDR_COMPANY_OFS})
					company <= ioctl_dout[7:0];

				// Masks trail the header fields by one write
				rom_mask <= (MASK_W'(1024) << rom_size_eff) - 1'b1;
				ram_mask <= (ram_size != 4'd0) ? (MASK_W'(1024) << ram_size) - 1'b1 : '0;
			end
		end else begin
			pal <= video_region;
			if (chip != CHIP_NONE)
				rom_type[7:4] <= chip;
			// GSU carts get a fixed save RAM
			if (chip == CHIP_GSU)
				ram_mask <= (MASK_W'(1024) << GSU_RAM_SIZE_CODE) - 1'b1;
		end
	end

endmodule

// File: design/sdram_req_gen.sv
/*
 * SDRAM request generator
 * Turns ROM and work-RAM strobes into toggle requests on the shared
 * SDRAM port and picks the returned bytes
 */
`timescale 1ns/100ps

module sdram_req_gen import snes_mem_pkg::*; (
	input  logic                clk_sys,
	input  logic                RESET_N,
	input  logic                cart_download,
	input  logic                ioctl_wr,
	input  logic [ROM_AW-1:0]   cart_addr,
	input  logic [15:0]         ioctl_dout,
	input  logic                rom_ce_n,
	input  logic                rom_word,
	input  logic [ROM_AW-1:0]   rom_addr,
	input  logic                wram_ce_n,
	input  logic                wram_rd_n,
	input  logic                wram_we_n,
	input  logic [WRAM_AW-1:0]  wram_addr,
	input  logic [7:0]          wram_d,
	input  logic [15:0]         sdram_port0_q,
	input  logic [15:0]         sdram_port1_q,
	output logic                sdram_req,
	output logic [SDRAM_AW-1:0] sdram_addr,
	output logic [15:0]         sdram_din,
	output logic                sdram_we,
	output logic [1:0]          sdram_ds,
	output logic                sdram_port,
	output logic [15:0]         rom_q,
	output logic [7:0]          wram_q
);

	logic [ROM_AW-1:0]  rom_addr_rw;
	logic [ROM_AW-1:1]  rom_last;
	logic [WRAM_AW-1:1] wram_last;
	logic               wram_rd;
	logic               wram_wr;
	logic               wram_rd_q;
	logic               wram_wr_q;
	logic               rom_trig;
	logic               wram_trig;

	assign rom_addr_rw = cart_download ? cart_addr : rom_addr;
	assign wram_rd     = !wram_ce_n && !wram_rd_n;
	assign wram_wr     = !wram_ce_n && !wram_we_n;

	assign rom_trig = (cart_download && ioctl_wr) ||
		(!cart_download && !rom_ce_n && rom_addr_rw[ROM_AW-1:1] != rom_last);
	// A read that lost to ROM retries through the address compare
	assign wram_trig = (wram_rd && wram_addr[WRAM_AW-1:1] != wram_last) ||
		(wram_rd && !wram_rd_q) || (wram_wr && !wram_wr_q);

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			sdram_req <= 1'b0;
			rom_last  <= '1;
			wram_last <= '1;
			wram_rd_q <= 1'b0;
			wram_wr_q <= 1'b0;
		end else begin
			wram_rd_q <= wram_rd;
			wram_wr_q <= wram_wr;
			if (rom_trig) begin
				rom_last   <= rom_addr_rw[ROM_AW-1:1];
				sdram_req  <= ~sdram_req;
				sdram_addr <= rom_addr_rw[ROM_AW-1:1];
				sdram_we   <= cart_download;
				sdram_din  <= ioctl_dout;
				sdram_ds   <= 2'b11;
				sdram_port <= 1'b0;
			end else if (wram_trig) begin
				wram_last  <= wram_addr[WRAM_AW-1:1];
				sdram_req  <= ~sdram_req;
				sdram_addr <= {WRAM_SDRAM_BASE, wram_addr[WRAM_AW-1:1]};
				sdram_we   <= wram_wr;
				sdram_din  <= {wram_d, wram_d};
				sdram_ds   <= {wram_addr[0], !wram_addr[0]};
				sdram_port <= 1'b1;
			end
		end
	end

	// Odd byte reads see the high byte on the low lane
	assign rom_q  = (rom_word || !rom_addr[0]) ? sdram_port0_q :
		{sdram_port0_q[7:0], sdram_port0_q[15:8]};
	assign wram_q = wram_addr[0] ? sdram_port1_q[15:8] : sdram_port1_q[7:0];

	a_req_has_lanes: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		$changed(sdram_req) |-> sdram_ds != 2'b00);

endmodule

// File: design/backup_ram_ctrl.sv
/*
 * Backup RAM transfer
 * Copies battery save RAM between the SD card image and the SDRAM
 * save area one 512-byte sector at a time
 */
`timescale 1ns/100ps

module backup_ram_ctrl import snes_mem_pkg::*; (
	input  logic                clk_sys,
	input  logic                RESET_N,
	input  logic                img_mounted,
	input  logic [31:0]         img_size,
	input  logic                bk_save,
	input  logic                dl_start,
	input  logic                sd_ack,
	input  logic [8:0]          sd_buff_addr,
	input  logic [7:0]          sd_buff_dout,
	input  logic                sd_buff_wr,
	input  logic                sd_buff_rd,
	input  logic [15:0]         bsram_io_q,
	output logic [31:0]         sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic [7:0]          sd_buff_din,
	output logic [BSRAM_AW-1:1] bsram_io_addr,
	output logic [15:0]         bsram_io_d,
	output logic                bsram_io_req,
	output logic                bsram_io_we,
	output logic                halt,
	output logic                led
);

	bk_state_e               bk_state;
	logic                    bk_ena;
	logic                    bk_load;
	logic                    mounted_q;
	logic                    load_q;
	logic                    save_q;
	logic                    ack_q;
	logic [SAV_SECTOR_W-1:0] sav_size;
	logic [15:0]             q_save;

	assign halt        = (bk_state == BK_BUSY);
	assign bsram_io_we = bk_load;
	assign led         = !(halt || bk_ena);
	assign sd_buff_din = sd_buff_addr[0] ? q_save[15:8] : q_save[7:0];

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			bk_state     <= BK_IDLE;
			bk_ena       <= 1'b0;
			bk_load      <= 1'b0;
			sd_rd        <= 1'b0;
			sd_wr        <= 1'b0;
			bsram_io_req <= 1'b0;
			mounted_q    <= 1'b0;
			load_q       <= 1'b0;
			save_q       <= 1'b0;
			ack_q        <= 1'b0;
		end else begin
			mounted_q <= img_mounted;
			load_q    <= bk_load;
			save_q    <= bk_save;
			ack_q     <= sd_ack;

			if (img_mounted && !mounted_q) begin
				bk_ena <= (img_size != 32'd0);
				if (img_size != 32'd0) begin
					bk_load  <= 1'b1;
					sav_size <= img_size[SAV_SECTOR_W+8:9];
				end
			end
			// A new download invalidates the mounted save
			if (dl_start)
				bk_ena <= 1'b0;

			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			// ==========================================================
			// Sector sequencing
			// ==========================================================
			case (bk_state)
				BK_IDLE: begin
					if (bk_ena && ((bk_load && !load_q) || (bk_save && !save_q))) begin
						bk_state <= BK_BUSY;
						sd_lba   <= 32'd0;
						sd_rd    <= bk_load;
						sd_wr    <= !bk_load;
						if (!bk_load) begin
							bsram_io_addr <= '0;
							bsram_io_req  <= ~bsram_io_req;
						end else begin
							bsram_io_addr <= '1;
						end
					end
				end
				BK_BUSY: begin
					if (ack_q && !sd_ack) begin
						if (sd_lba[SAV_SECTOR_W-1:0] == sav_size) begin
							bk_load  <= 1'b0;
							bk_state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_load;
							sd_wr  <= !bk_load;
						end
					end
				end
				default: bk_state <= BK_IDLE;
			endcase

			// Load path, odd byte closes the word
			if (sd_buff_wr) begin
				if (sd_buff_addr[0]) begin
					bsram_io_d[15:8] <= sd_buff_dout;
					bsram_io_req     <= ~bsram_io_req;
					bsram_io_addr    <= bsram_io_addr + 1'b1;
				end else begin
					bsram_io_d[7:0] <= sd_buff_dout;
				end
			end

			// Save path, fetch of the next word starts after the odd byte
			if (!sd_buff_addr[0])
				q_save <= bsram_io_q;
			if (sd_buff_rd && sd_buff_addr[0]) begin
				bsram_io_req  <= ~bsram_io_req;
				bsram_io_addr <= bsram_io_addr + 1'b1;
			end
		end
	end

	a_sd_req_in_busy: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		(sd_rd || sd_wr) |-> halt);

endmodule

// File: design/snes_mem_top.sv
/*
 * SNES memory-side core
 * Loader, header detection, SDRAM requests and save-RAM transfer
 */
`timescale 1ns/100ps

module snes_mem_top import snes_mem_pkg::*; (
	input  logic                clk_sys,
	input  logic                RESET_N,
	input  logic                user_reset,
	// Loader
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic                ioctl_wr,
	input  logic [24:0]         ioctl_addr,
	input  logic [15:0]         ioctl_dout,
	input  logic [23:0]         ioctl_filesize,
	input  map_mode_e           map_mode,
	input  logic                video_region,
	output logic                spc_mode,
	output logic                core_reset_n,
	output logic [7:0]          rom_type,
	output logic [MASK_W-1:0]   rom_mask,
	output logic [MASK_W-1:0]   ram_mask,
	output logic                pal,
	// Core memory strobes
	input  logic                rom_ce_n,
	input  logic                rom_word,
	input  logic [ROM_AW-1:0]   rom_addr,
	input  logic                wram_ce_n,
	input  logic                wram_rd_n,
	input  logic                wram_we_n,
	input  logic [WRAM_AW-1:0]  wram_addr,
	input  logic [7:0]          wram_d,
	output logic [15:0]         rom_q,
	output logic [7:0]          wram_q,
	// SDRAM port
	input  logic [15:0]         sdram_port0_q,
	input  logic [15:0]         sdram_port1_q,
	output logic                sdram_req,
	output logic [SDRAM_AW-1:0] sdram_addr,
	output logic [15:0]         sdram_din,
	output logic                sdram_we,
	output logic [1:0]          sdram_ds,
	output logic                sdram_port,
	// SD card and save RAM
	input  logic                img_mounted,
	input  logic [31:0]         img_size,
	input  logic                bk_save,
	input  logic                sd_ack,
	input  logic [8:0]          sd_buff_addr,
	input  logic [7:0]          sd_buff_dout,
	input  logic                sd_buff_wr,
	input  logic                sd_buff_rd,
	input  logic [15:0]         bsram_io_q,
	output logic [31:0]         sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic [7:0]          sd_buff_din,
	output logic [BSRAM_AW-1:1] bsram_io_addr,
	output logic [15:0]         bsram_io_d,
	output logic                bsram_io_req,
	output logic                bsram_io_we,
	output logic                halt,
	output logic                led
);

	logic              cart_download;
	logic              dl_start;
	logic [ROM_AW-1:0] cart_addr;

	load_ctrl load_ctrl_i (.*);

	cart_header_detect cart_header_detect_i (.*);

	sdram_req_gen sdram_req_gen_i (.*);

	backup_ram_ctrl backup_ram_ctrl_i (.*);

endmodule

// File: tests/tb_checks.svh
/*
 * Testbench helpers
 * Value check, bounded waits and cartridge download tasks
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic fail_run(input string why);
	$display("%s", why);
	$display("Test failed");
	$fatal(1);
endtask

task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		fail_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp));
endtask

// ==========================================================
// Bounded waits, sampled on falling edges
// ==========================================================
task automatic wait_core_run(input int limit);
	int n;
	for (n = 0; n < limit && !core_reset_n; n++)
		@(negedge clk_sys);
	if (!core_reset_n)
		fail_run("core_reset_n stayed low after reset release");
endtask

task automatic wait_sd_rd(input int limit);
	int n;
	for (n = 0; n < limit && !sd_rd; n++)
		@(negedge clk_sys);
	if (!sd_rd)
		fail_run("sd_rd never rose for the next sector");
endtask

task automatic wait_halt_low(input int limit);
	int n;
	for (n = 0; n < limit && halt; n++)
		@(negedge clk_sys);
	if (halt)
		fail_run("halt stayed high after the last sector");
endtask

// ==========================================================
// Loader
// ==========================================================
task automatic start_download(input logic [7:0] index);
	ioctl_index    = index;
	// Low bits of 512 mark a copier header
	ioctl_filesize = 24'h400200;
	ioctl_download = 1'b1;
	@(negedge clk_sys);
endtask

// One word write, also checks the SDRAM write request it causes
task automatic cart_write(input logic [24:0] byte_addr, input logic [15:0] data);
	logic        req_before;
	logic [24:0] rom_byte;
	req_before = sdram_req;
	rom_byte   = byte_addr - 25'd512;
	ioctl_addr = byte_addr;
	ioctl_dout = data;
	ioctl_wr   = 1'b1;
	@(negedge clk_sys);
	ioctl_wr = 1'b0;
	check("download request toggle", sdram_req, !req_before);
	check("download sdram_we", sdram_we, 1'b1);
	check("download sdram_ds", sdram_ds, 2'b11);
	check("download sdram_port", sdram_port, 1'b0);
	check("download sdram_addr", sdram_addr, rom_byte[23:1]);
	check("download sdram_din", sdram_din, data);
	@(negedge clk_sys);
endtask

task automatic end_download;
	ioctl_download = 1'b0;
	repeat (2) @(negedge clk_sys);
endtask

`endif

// File: tests/tb_snes_mem_top.sv
/*
 * Testbench for the SNES memory-side core
 * Cartridge header table, ROM and work-RAM requests, save-RAM load
 */
`timescale 1ns/100ps

module tb_snes_mem_top import snes_mem_pkg::*; ();

	logic                clk_sys;
	logic                RESET_N;
	logic                user_reset;
	logic                ioctl_download;
	logic [7:0]          ioctl_index;
	logic                ioctl_wr;
	logic [24:0]         ioctl_addr;
	logic [15:0]         ioctl_dout;
	logic [23:0]         ioctl_filesize;
	map_mode_e           map_mode;
	logic                video_region;
	logic                spc_mode;
	logic                core_reset_n;
	logic [7:0]          rom_type;
	logic [MASK_W-1:0]   rom_mask;
	logic [MASK_W-1:0]   ram_mask;
	logic                pal;
	logic                rom_ce_n;
	logic                rom_word;
	logic [ROM_AW-1:0]   rom_addr;
	logic                wram_ce_n;
	logic                wram_rd_n;
	logic                wram_we_n;
	logic [WRAM_AW-1:0]  wram_addr;
	logic [7:0]          wram_d;
	logic [15:0]         rom_q;
	logic [7:0]          wram_q;
	logic [15:0]         sdram_port0_q;
	logic [15:0]         sdram_port1_q;
	logic                sdram_req;
	logic [SDRAM_AW-1:0] sdram_addr;
	logic [15:0]         sdram_din;
	logic                sdram_we;
	logic [1:0]          sdram_ds;
	logic                sdram_port;
	logic                img_mounted;
	logic [31:0]         img_size;
	logic                bk_save;
	logic                sd_ack;
	logic [8:0]          sd_buff_addr;
	logic [7:0]          sd_buff_dout;
	logic                sd_buff_wr;
	logic                sd_buff_rd;
	logic [15:0]         bsram_io_q;
	logic [31:0]         sd_lba;
	logic                sd_rd;
	logic                sd_wr;
	logic [7:0]          sd_buff_din;
	logic [BSRAM_AW-1:1] bsram_io_addr;
	logic [15:0]         bsram_io_d;
	logic                bsram_io_req;
	logic                bsram_io_we;
	logic                halt;
	logic                led;

	typedef struct packed {
		map_mode_e   mode;
		logic [7:0]  mapper;
		logic [7:0]  rtype;
		logic [7:0]  company;
		logic [3:0]  size_code;
		logic [3:0]  ram_code;
		chip_e       chip;
		logic [23:0] exp_rom_mask;
		logic [23:0] exp_ram_mask;
	} hdr_row_t;

	hdr_row_t rows [0:10];

	snes_mem_top dut_i (.*);

	`include "tb_checks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ==========================================================
	// Header table, masks worked out by hand
	// ==========================================================
	task automatic fill_table;
		rows[0]  = {LOROM, 8'h20, 8'h00, 8'h00, 4'd8, 4'd0, CHIP_NONE, 24'h03FFFF, 24'h0};
		rows[1]  = {LOROM, 8'h30, 8'h05, 8'hB2, 4'd9, 4'd3, CHIP_DSP3, 24'h07FFFF, 24'h1FFF};
		rows[2]  = {HIROM, 8'h31, 8'h03, 8'h00, 4'd10, 4'd1, CHIP_DSP1, 24'h0FFFFF, 24'h7FF};
		rows[3]  = {LOROM, 8'h30, 8'h05, 8'h00, 4'd8, 4'd1, CHIP_DSP1, 24'h03FFFF, 24'h7FF};
		rows[4]  = {LOROM, 8'h20, 8'h05, 8'h00, 4'd5, 4'd0, CHIP_DSP2, 24'h01FFFF, 24'h0};
		rows[5]  = {LOROM, 8'h30, 8'h03, 8'h00, 4'd7, 4'd2, CHIP_DSP4, 24'h01FFFF, 24'hFFF};
		rows[6]  = {LOROM, 8'h30, 8'h25, 8'h00, 4'd9, 4'd3, CHIP_OBC1, 24'h07FFFF, 24'h1FFF};
		rows[7]  = {LOROM, 8'h32, 8'h45, 8'h00, 4'd12, 4'd5, CHIP_SDD1, 24'h3FFFFF, 24'h7FFF};
		rows[8]  = {LOROM, 8'h20, 8'h1A, 8'h00, 4'd10, 4'd0, CHIP_GSU, 24'h0FFFFF, 24'hFFFF};
		rows[9]  = {HIROM, 8'h23, 8'h35, 8'h00, 4'd11, 4'd2, CHIP_SA1, 24'h1FFFFF, 24'hFFF};
		rows[10] = {EXHIROM, 8'h35, 8'h00, 8'h00, 4'd12, 4'd3, CHIP_NONE, 24'h3FFFFF, 24'h1FFF};
	endtask

	task automatic download_row(input hdr_row_t r, input int idx);
		logic [23:0] hdr;
		int          i;
		case (r.mode)
			HIROM:   hdr = 24'h008000;
			EXHIROM: hdr = 24'h408000;
			default: hdr = 24'h000000;
		endcase
		map_mode     = r.mode;
		video_region = idx[0];
		start_download(8'(idx % 2));
		cart_write(25'd512, 16'($urandom));
		for (i = 1; i < 5; i++)
			cart_write(25'(512 + 2 * i), 16'($urandom));
		cart_write(25'(512 + hdr + 24'h7FD4), {r.mapper, 8'h20});
		cart_write(25'(512 + hdr + 24'h7FD6), {4'h0, r.size_code, r.rtype});
		cart_write(25'(512 + hdr + 24'h7FD8), {8'h01, 4'h0, r.ram_code});
		cart_write(25'(512 + hdr + 24'h7FDA), {8'h00, r.company});
		// Masks need one more write after the header
		cart_write(25'(512 + hdr + 24'h7FDC), 16'($urandom));
		end_download();
		check("rom_type", rom_type, {r.chip, 2'b00, r.mode});
		check("rom_mask", rom_mask, r.exp_rom_mask);
		check("ram_mask", ram_mask, r.exp_ram_mask);
		check("pal", pal, idx[0]);
	endtask

	task automatic spc_seq;
		logic req_before;
		check("spc_mode after cart loads", spc_mode, 1'b0);
		req_before     = sdram_req;
		ioctl_index    = 8'd2;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check("spc_mode after spc write", spc_mode, 1'b1);
		check("spc write no request", sdram_req, req_before);
		ioctl_download = 1'b0;
		user_reset     = 1'b1;
		@(negedge clk_sys);
		user_reset = 1'b0;
		check("spc_mode after user reset", spc_mode, 1'b0);
	endtask

	task automatic rom_read(input logic [23:0] a, input logic word, input logic new_word,
			input logic [15:0] exp_q);
		logic req_before;
		req_before = sdram_req;
		rom_addr   = a;
		rom_word   = word;
		rom_ce_n   = 1'b0;
		@(negedge clk_sys);
		check("rom request toggle", sdram_req, new_word ? !req_before : req_before);
		if (new_word) begin
			check("rom sdram_we", sdram_we, 1'b0);
			check("rom sdram_port", sdram_port, 1'b0);
			check("rom sdram_addr", sdram_addr, a[23:1]);
		end
		check("rom_q", rom_q, exp_q);
	endtask

	task automatic wram_seq;
		logic req_before;
		sdram_port1_q = 16'hC3E1;
		req_before    = sdram_req;
		wram_addr     = 17'h0ABC5;
		wram_d        = 8'h3C;
		wram_ce_n     = 1'b0;
		wram_we_n     = 1'b0;
		@(negedge clk_sys);
		check("wram write toggle", sdram_req, !req_before);
		check("wram write sdram_we", sdram_we, 1'b1);
		check("wram write sdram_port", sdram_port, 1'b1);
		check("wram write sdram_ds", sdram_ds, 2'b10);
		check("wram write sdram_din", sdram_din, 16'h3C3C);
		check("wram write sdram_addr", sdram_addr, {WRAM_SDRAM_BASE, 16'h55E2});
		wram_we_n = 1'b1;
		wram_ce_n = 1'b1;
		@(negedge clk_sys);
		req_before = sdram_req;
		wram_addr  = 17'h0ABC4;
		wram_ce_n  = 1'b0;
		wram_rd_n  = 1'b0;
		@(negedge clk_sys);
		check("wram read toggle", sdram_req, !req_before);
		check("wram read sdram_we", sdram_we, 1'b0);
		check("wram read sdram_ds", sdram_ds, 2'b01);
		check("wram_q even", wram_q, 8'hE1);
		// Same word, read held, so no new request
		req_before = sdram_req;
		wram_addr  = 17'h0ABC5;
		@(negedge clk_sys);
		check("wram read no toggle", sdram_req, req_before);
		check("wram_q odd", wram_q, 8'hC3);
		wram_ce_n = 1'b1;
		wram_rd_n = 1'b1;
	endtask

	// ==========================================================
	// SD card model
	// ==========================================================
	function automatic logic [7:0] img_byte(input logic [10:0] a);
		return a[7:0] + {a[10:8], 5'b10011};
	endfunction

	task automatic serve_sector(input int sector);
		int          b;
		logic [10:0] a;
		logic [15:0] w;
		logic [7:0]  exp_din;
		logic        req_before;
		wait_sd_rd(16);
		check("sd_lba", sd_lba, sector);
		check("halt during sector", halt, 1'b1);
		check("bsram_io_we", bsram_io_we, 1'b1);
		sd_ack = 1'b1;
		@(negedge clk_sys);
		for (b = 0; b < 512; b++) begin
			a            = 11'(sector * 512 + b);
			w            = {a[8:1], ~a[8:1]};
			exp_din      = a[0] ? a[8:1] : ~a[8:1];
			req_before   = bsram_io_req;
			sd_buff_addr = 9'(b);
			sd_buff_dout = img_byte(a);
			sd_buff_wr   = 1'b1;
			// Inverted word on the odd byte must not reach sd_buff_din
			bsram_io_q   = a[0] ? ~w : w;
			@(negedge clk_sys);
			check("sd_buff_din", sd_buff_din, exp_din);
			if (a[0]) begin
				check("bsram_io_req toggle", bsram_io_req, !req_before);
				check("bsram_io_d", bsram_io_d, {img_byte(a), img_byte(a - 11'd1)});
				check("bsram_io_addr", bsram_io_addr, a[10:1]);
			end
		end
		sd_buff_wr = 1'b0;
		check("sd_rd after ack", sd_rd, 1'b0);
		check("halt after sector data", halt, 1'b1);
		sd_ack = 1'b0;
		@(negedge clk_sys);
	endtask

	initial begin
		int          i;
		int unsigned seed_val;
		seed_val       = $urandom(32'h4b931694);
		RESET_N        = 1'b0;
		user_reset     = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_filesize = '0;
		map_mode       = LOROM;
		video_region   = 1'b1;
		rom_ce_n       = 1'b1;
		rom_word       = 1'b0;
		rom_addr       = '0;
		wram_ce_n      = 1'b1;
		wram_rd_n      = 1'b1;
		wram_we_n      = 1'b1;
		wram_addr      = '0;
		wram_d         = '0;
		sdram_port0_q  = '0;
		sdram_port1_q  = '0;
		img_mounted    = 1'b0;
		img_size       = '0;
		bk_save        = 1'b0;
		sd_ack         = 1'b0;
		sd_buff_addr   = '0;
		sd_buff_dout   = '0;
		sd_buff_wr     = 1'b0;
		sd_buff_rd     = 1'b0;
		bsram_io_q     = '0;
		fill_table();

		repeat (8) @(negedge clk_sys);
		check("reset sdram_req", sdram_req, 1'b0);
		check("reset sd_rd", sd_rd, 1'b0);
		check("reset sd_wr", sd_wr, 1'b0);
		check("reset halt", halt, 1'b0);
		check("reset core_reset_n", core_reset_n, 1'b0);
		RESET_N = 1'b1;
		wait_core_run(4);

		for (i = 0; i < 11; i++)
			download_row(rows[i], i);

		spc_seq();

		sdram_port0_q = 16'h12C7;
		rom_read(24'h001235, 1'b0, 1'b1, 16'hC712);
		rom_read(24'h001234, 1'b0, 1'b0, 16'h12C7);
		rom_read(24'h001235, 1'b1, 1'b0, 16'h12C7);
		rom_read(24'h2ABCDE, 1'b0, 1'b1, 16'h12C7);
		rom_ce_n = 1'b1;

		wram_seq();

		// 1024-byte save image, three sectors
		img_size    = 32'd1024;
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		for (i = 0; i < 3; i++)
			serve_sector(i);
		wait_halt_low(8);
		check("sd_rd at end", sd_rd, 1'b0);
		check("led with backup enabled", led, 1'b0);

		$display("Test passed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+tests
design/snes_mem_pkg.sv
design/load_ctrl.sv
design/cart_header_detect.sv
design/sdram_req_gen.sv
design/backup_ram_ctrl.sv
design/snes_mem_top.sv
tests/tb_snes_mem_top.sv

// File: Bender.yml
package:
  name: snes_mem

sources:
  - files:
      - design/snes_mem_pkg.sv
      - design/load_ctrl.sv
      - design/cart_header_detect.sv
      - design/sdram_req_gen.sv
      - design/backup_ram_ctrl.sv
      - design/snes_mem_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_snes_mem_top.sv
